// File: des_round.f
logic/des_round_pkg.sv
logic/round_feed.sv
logic/sbox_lookup.sv
logic/round_drain.sv
logic/des_round.sv
tests/des_round_tb.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module des_round_tb \
  -f des_round.f \
  -o sim_des_round > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/sim_des_round > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST RESULT: PASS" "$SIM_LOG"; then
  exit 0
fi
exit 1

// File: tests/des_round_tb.sv
`timescale 1ns/1ps

module des_round_tb;
  import des_round_pkg::*;

  // longest run is about 1400 cycles
  localparam int TIMEOUT_CYCLES = 3000;

  logic    clk;
  logic    arst_n;
  block_t  block;
  subkey_t subkey;
  logic    in_valid;
  block_t  cipher;
  logic    out_valid;

  int cycle_count = 0;
  int checks = 0;
  int errors = 0;
  int err_mark;

  // expected results in flight, oldest first
  block_t  exp_q[$];
  block_t  blk_q[$];
  int      due_q[$];

  block_t  exp_c;
  block_t  src_blk;
  block_t  ip_out;
  block_t  ip_in;
  int      due;

  des_round UUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .block     (block),
    .subkey    (subkey),
    .in_valid  (in_valid),
    .cipher    (cipher),
    .out_valid (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: run stopped after %0d cycles without finishing", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic block_t apply_ip(input block_t b);
    block_t res;
    for (int i = 0; i < BLOCK_W; i++) begin
      res[BLOCK_W-1-i] = b[BLOCK_W-IP_TABLE[i]];
    end
    return res;
  endfunction

  function automatic block_t des_round_model(input block_t b, input subkey_t k);
    block_t     ip;
    block_t     swapped;
    block_t     res;
    half_t      l;
    half_t      r;
    half_t      s_out;
    half_t      f;
    subkey_t    mixed;
    logic [5:0] six;
    logic [1:0] row;
    logic [3:0] col;
    ip = apply_ip(b);
    l = ip[BLOCK_W-1:HALF_W];
    r = ip[HALF_W-1:0];
    for (int i = 0; i < EXP_W; i++) begin
      mixed[EXP_W-1-i] = r[HALF_W-E_TABLE[i]] ^ k[EXP_W-1-i];
    end
    for (int bx = 0; bx < SBOX_COUNT; bx++) begin
      for (int j = 0; j < SBOX_IN_W; j++) begin
        six[SBOX_IN_W-1-j] = mixed[EXP_W-1-bx*SBOX_IN_W-j];
      end
      row = {six[5], six[0]};
      col = six[4:1];
      for (int j = 0; j < SBOX_OUT_W; j++) begin
        s_out[HALF_W-1-bx*SBOX_OUT_W-j] = SBOX_TABLE[bx][row][col][SBOX_OUT_W-1-j];
      end
    end
    for (int i = 0; i < HALF_W; i++) begin
      f[HALF_W-1-i] = s_out[HALF_W-P_TABLE[i]];
    end
    swapped = {r, l ^ f};
    for (int i = 0; i < BLOCK_W; i++) begin
      res[BLOCK_W-1-i] = swapped[BLOCK_W-IP_INV_TABLE[i]];
    end
    return res;
  endfunction

  function automatic block_t rand_block();
    return {$urandom, $urandom};
  endfunction

  function automatic subkey_t rand_subkey();
    logic [63:0] raw;
    raw = {$urandom, $urandom};
    return raw[EXP_W-1:0];
  endfunction

  // reference plaintexts and alternating keys
  function automatic block_t corner_block(input int idx);
    case (idx)
      0:       return 64'h0000_0000_0000_0000;
      1:       return 64'hFFFF_FFFF_FFFF_FFFF;
      2:       return 64'h0123_4567_89AB_CDEF;
      default: return 64'h4E6F_7720_6973_2074;
    endcase
  endfunction

  function automatic subkey_t corner_key(input int idx);
    case (idx)
      0:       return 48'h0000_0000_0000;
      1:       return 48'hFFFF_FFFF_FFFF;
      2:       return 48'hAAAA_AAAA_AAAA;
      default: return 48'h5555_5555_5555;
    endcase
  endfunction

  task automatic send_block(input block_t b, input subkey_t k);
    @(negedge clk);
    block    = b;
    subkey   = k;
    in_valid = 1'b1;
    exp_q.push_back(des_round_model(b, k));
    blk_q.push_back(b);
    // sampled at the next edge, out_valid after the one that follows
    due_q.push_back(cycle_count + 2);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic check_idle();
    checks++;
    if (out_valid !== 1'b0 || cipher !== '0) begin
      $display("MISMATCH at %0t: idle output out_valid %b cipher %h", $time, out_valid, cipher);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int mark);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    $display("%s: finished with %0d errors", name, errors - mark);
  endtask

  always @(negedge clk) begin
    if (arst_n) begin
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t: out_valid high with no block in flight", $time);
          errors++;
        end else begin
          exp_c   = exp_q.pop_front();
          src_blk = blk_q.pop_front();
          due     = due_q.pop_front();
          checks++;
          if (cipher !== exp_c) begin
            $display("MISMATCH at %0t: cipher %h, expected %h for block %h",
                     $time, cipher, exp_c, src_blk);
            errors++;
          end
          if (due != cycle_count) begin
            $display("ERROR at %0t: result came in cycle %0d instead of cycle %0d",
                     $time, cycle_count, due);
            errors++;
          end
          // left half after IP must be the old right half
          ip_out = apply_ip(cipher);
          ip_in  = apply_ip(src_blk);
          if (ip_out[BLOCK_W-1:HALF_W] !== ip_in[HALF_W-1:0]) begin
            $display("MISMATCH at %0t: half swap broken, %h vs %h", $time,
                     ip_out[BLOCK_W-1:HALF_W], ip_in[HALF_W-1:0]);
            errors++;
          end
        end
      end else if (exp_q.size() != 0 && due_q[0] <= cycle_count) begin
        $display("ERROR at %0t: no result arrived for block %h", $time, blk_q[0]);
        errors++;
        void'(exp_q.pop_front());
        void'(blk_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  initial begin
    void'($urandom(32'h5190_0306));
    arst_n   = 1'b0;
    block    = '0;
    subkey   = '0;
    in_valid = 1'b0;

    err_mark = errors;
    repeat (10) begin
      @(negedge clk);
      check_idle();
    end
    arst_n = 1'b1;
    repeat (5) begin
      @(negedge clk);
      check_idle();
    end
    report_test("reset and idle", err_mark);

    err_mark = errors;
    repeat (200) begin
      send_block(rand_block(), rand_subkey());
      idle_cycles($urandom_range(3, 1));
    end
    report_test("single blocks", err_mark);

    err_mark = errors;
    repeat (500) begin
      send_block(rand_block(), rand_subkey());
    end
    idle_cycles(1);
    report_test("streaming", err_mark);

    err_mark = errors;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        send_block(corner_block(i), corner_key(j));
        idle_cycles(2);
      end
    end
    report_test("corner vectors", err_mark);

    err_mark = errors;
    repeat (100) begin
      send_block(rand_block(), rand_subkey());
      idle_cycles($urandom_range(2, 0));
    end
    idle_cycles(1);
    report_test("half swap", err_mark);

    if (exp_q.size() != 0) begin
      $display("ERROR: %0d results still outstanding at end of run", exp_q.size());
      errors++;
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: logic/des_round.sv
`timescale 1ns/1ps

module des_round (
  input  logic                   clk,
  input  logic                   arst_n,
  input  des_round_pkg::block_t  block,
  input  des_round_pkg::subkey_t subkey,
  input  logic                   in_valid,
  output des_round_pkg::block_t  cipher,
  output logic                   out_valid
);
  import des_round_pkg::*;

  mix_stage_t mix;
  half_t      sbox_result;

  round_feed u_feed (
    .clk      (clk),
    .arst_n   (arst_n),
    .block    (block),
    .subkey   (subkey),
    .in_valid (in_valid),
    .mix      (mix)
  );

  // box 0 takes the most significant slice
  for (genvar i = 0; i < SBOX_COUNT; i++) begin : g_sbox
    sbox_lookup #(
      .BOX (i)
    ) u_sbox (
      .bits   (mix.mixed[EXP_W-1-i*SBOX_IN_W -: SBOX_IN_W]),
      .nibble (sbox_result[HALF_W-1-i*SBOX_OUT_W -: SBOX_OUT_W])
    );
  end

  round_drain u_drain (
    .clk         (clk),
    .arst_n      (arst_n),
    .mix         (mix),
    .sbox_result (sbox_result),
    .cipher      (cipher),
    .out_valid   (out_valid)
  );

endmodule

// File: logic/round_drain.sv
`timescale 1ns/1ps

module round_drain (
  input  logic                      clk,
  input  logic                      arst_n,
  input  des_round_pkg::mix_stage_t mix,
  input  des_round_pkg::half_t      sbox_result,
  output des_round_pkg::block_t     cipher,
  output logic                      out_valid
);
  import des_round_pkg::*;

  half_t  f_out;
  half_t  new_right;
  block_t swapped;
  block_t cipher_d;

  // P permutation of the s-box nibbles
  always_comb begin
    for (int i = 0; i < HALF_W; i++) begin
      f_out[HALF_W-1-i] = sbox_result[HALF_W-P_TABLE[i]];
    end
  end

  assign new_right = mix.left ^ f_out;
  assign swapped   = {mix.right, new_right};

  always_comb begin
    for (int i = 0; i < BLOCK_W; i++) begin
      cipher_d[BLOCK_W-1-i] = swapped[BLOCK_W-IP_INV_TABLE[i]];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      cipher    <= '0;
    end else begin
      out_valid <= mix.valid;
      if (mix.valid) begin
        cipher <= cipher_d;
      end
    end
  end

  // feed halves and s-box nibbles known whenever the stage is valid
  a_input_known: assert property (@(posedge clk) disable iff (!arst_n)
    mix.valid |-> !$isunknown({mix.left, mix.right, sbox_result}));

  a_cipher_known: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> !$isunknown(cipher));

endmodule

// File: logic/sbox_lookup.sv
`timescale 1ns/1ps

module sbox_lookup #(
  parameter int BOX = 0
) (
  input  des_round_pkg::sbox_in_t  bits,
  output des_round_pkg::sbox_out_t nibble
);
  import des_round_pkg::*;

  logic [1:0] row;
  logic [3:0] col;

  // outer bits pick the row, inner four the column
  assign row = {bits[SBOX_IN_W-1], bits[0]};
  assign col = bits[SBOX_IN_W-2:1];

  assign nibble = SBOX_TABLE[BOX][row][col];

  initial begin
    assert (BOX >= 0 && BOX < SBOX_COUNT)
      else $fatal(1, "sbox_lookup: box index %0d out of range", BOX);
  end

endmodule

// File: logic/round_feed.sv
`timescale 1ns/1ps

module round_feed (
  input  logic                      clk,
  input  logic                      arst_n,
  input  des_round_pkg::block_t     block,
  input  des_round_pkg::subkey_t    subkey,
  input  logic                      in_valid,
  output des_round_pkg::mix_stage_t mix
);
  import des_round_pkg::*;

  block_t  ip_block;
  half_t   right_half;
  subkey_t expanded;

  logic    valid_q;
  half_t   left_q;
  half_t   right_q;
  subkey_t mixed_q;

  // initial permutation
  always_comb begin
    for (int i = 0; i < BLOCK_W; i++) begin
      ip_block[BLOCK_W-1-i] = block[BLOCK_W-IP_TABLE[i]];
    end
  end

  assign right_half = ip_block[HALF_W-1:0];

  always_comb begin
    for (int i = 0; i < EXP_W; i++) begin
      expanded[EXP_W-1-i] = right_half[HALF_W-E_TABLE[i]];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      left_q  <= ip_block[BLOCK_W-1:HALF_W];
      right_q <= right_half;
      mixed_q <= expanded ^ subkey;
    end
  end

  assign mix = '{valid: valid_q, left: left_q, right: right_q, mixed: mixed_q};

endmodule

// File: logic/des_round_pkg.sv
package des_round_pkg;

  localparam int BLOCK_W    = 64;
  localparam int HALF_W     = 32;
  localparam int EXP_W      = 48;
  localparam int SBOX_COUNT = 8;
  localparam int SBOX_IN_W  = 6;
  localparam int SBOX_OUT_W = 4;

  typedef logic [BLOCK_W-1:0]    block_t;
  typedef logic [HALF_W-1:0]     half_t;
  typedef logic [EXP_W-1:0]      subkey_t;
  typedef logic [SBOX_IN_W-1:0]  sbox_in_t;
  typedef logic [SBOX_OUT_W-1:0] sbox_out_t;

  // feed stage output, halves already permuted by IP
  typedef struct packed {
    logic                valid;
    half_t               left;
    half_t               right;
    logic [EXP_W-1:0]    mixed;
  } mix_stage_t;

  // all tables use DES numbering, position 1 is the msb
  localparam int IP_TABLE [BLOCK_W] = '{
    58, 50, 42, 34, 26, 18, 10, 2,
    60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6,
    64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17,  9, 1,
    59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5,
    63, 55, 47, 39, 31, 23, 15, 7
  };

  localparam int IP_INV_TABLE [BLOCK_W] = '{
    40, 8, 48, 16, 56, 24, 64, 32,
    39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30,
    37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28,
    35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26,
    33, 1, 41,  9, 49, 17, 57, 25
  };

  // expansion of the 32-bit right half
  localparam int E_TABLE [EXP_W] = '{
    32,  1,  2,  3,  4,  5,
     4,  5,  6,  7,  8,  9,
     8,  9, 10, 11, 12, 13,
    12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21,
    20, 21, 22, 23, 24, 25,
    24, 25, 26, 27, 28, 29,
    28, 29, 30, 31, 32,  1
  };

  localparam int P_TABLE [HALF_W] = '{
    16,  7, 20, 21, 29, 12, 28, 17,
     1, 15, 23, 26,  5, 18, 31, 10,
     2,  8, 24, 14, 32, 27,  3,  9,
    19, 13, 30,  6, 22, 11,  4, 25
  };

  // box, row, column
  localparam logic [SBOX_OUT_W-1:0] SBOX_TABLE [SBOX_COUNT][4][16] = '{
    '{
      '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7},
      '{ 0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8},
      '{ 4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0},
      '{15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13}
    },
    '{
      '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10},
      '{ 3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5},
      '{ 0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15},
      '{13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9}
    },
    '{
      '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8},
      '{13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1},
      '{13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7},
      '{ 1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12}
    },
    '{
      '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15},
      '{13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9},
      '{10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4},
      '{ 3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14}
    },
    '{
      '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9},
      '{14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6},
      '{ 4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14},
      '{11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3}
    },
    '{
      '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11},
      '{10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8},
      '{ 9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6},
      '{ 4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13}
    },
    '{
      '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1},
      '{13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6},
      '{ 1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2},
      '{ 6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12}
    },
    '{
      '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7},
      '{ 1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2},
      '{ 7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8},
      '{ 2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
    }
  };

endpackage
